/* common/rtc_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and register map of the MSX2 real-time clock.
// Every RTC block refers to these by scoped name.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package rtc_pkg;

    typedef logic [3:0] nibble_t;

    // Selected by mode bits [1:0]
    typedef enum logic [1:0] {
        bank_clock  = 2'd0,
        bank_config = 2'd1,
        bank_ram_lo = 2'd2,
        bank_ram_hi = 2'd3
    } rtc_bank_t;

    // Write bus; bank and ptr are valid in every cycle
    typedef struct packed {
        logic      en;
        rtc_bank_t bank;
        nibble_t   ptr;
        nibble_t   data;
    } reg_wr_t;

    // hou_h[1] is the afternoon flag in 12-hour mode
    typedef struct packed {
        logic [3:0] sec_l;
        logic [2:0] sec_h;
        logic [3:0] min_l;
        logic [2:0] min_h;
        logic [3:0] hou_l;
        logic [1:0] hou_h;
    } bcd_time_t;

    typedef struct packed {
        logic [2:0] wee;
        logic [3:0] day_l;
        logic [1:0] day_h;
        logic [3:0] mon_l;
        logic       mon_h;
        logic [3:0] yea_l;
        logic [3:0] yea_h;
        logic [1:0] leap;
    } bcd_date_t;

    // Clock bank register map
    localparam nibble_t reg_sec_l_addr = 4'd0;
    localparam nibble_t reg_sec_h_addr = 4'd1;
    localparam nibble_t reg_min_l_addr = 4'd2;
    localparam nibble_t reg_min_h_addr = 4'd3;
    localparam nibble_t reg_hou_l_addr = 4'd4;
    localparam nibble_t reg_hou_h_addr = 4'd5;
    localparam nibble_t reg_wee_addr   = 4'd6;
    localparam nibble_t reg_day_l_addr = 4'd7;
    localparam nibble_t reg_day_h_addr = 4'd8;
    localparam nibble_t reg_mon_l_addr = 4'd9;
    localparam nibble_t reg_mon_h_addr = 4'd10;
    localparam nibble_t reg_yea_l_addr = 4'd11;
    localparam nibble_t reg_yea_h_addr = 4'd12;

    // Mode register is visible in every bank
    localparam nibble_t reg_mode_addr  = 4'd13;
    // Config bank; data bit 1 restarts the prescaler
    localparam nibble_t reg_reset_addr = 4'd15;
    localparam nibble_t reg_1224_addr  = 4'd10;
    localparam nibble_t reg_leap_addr  = 4'd11;

    // Timer enabled, clock bank selected
    localparam nibble_t mode_reset_value = 4'b1000;
    localparam int      mode_te_bit      = 3;

endpackage

`default_nettype wire

/* verilog/rtc_backup_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Battery-backed RAM of the clock chip, 64 nibbles by bank and pointer.
// Synchronous read, output follows the address one cycle later.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rtc_backup_ram (
    input  logic             clk21m,
    input  rtc_pkg::reg_wr_t wr,
    output rtc_pkg::nibble_t ram_q
);

    rtc_pkg::nibble_t mem [64];
    logic [5:0]       addr;
    logic [5:0]       rd_addr_q;

    assign addr = {wr.bank, wr.ptr};

    // Every data write lands here, banks 0 and 1 just shadow the registers
    always_ff @(posedge clk21m) begin
        if (wr.en) begin
            mem[addr] <= wr.data;
        end
        rd_addr_q <= addr;
    end

    assign ram_q = mem[rd_addr_q];

endmodule

`default_nettype wire

/* verilog/rtc_bus_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host side of the RTC: pointer and mode registers, ack, the write bus
// to the counters and RAM, and the combinational read multiplexer.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rtc_bus_regs (
    input  logic               clk21m,
    input  logic               reset,
    input  logic               req,
    input  logic               wrt,
    input  logic               adr0,
    input  rtc_pkg::nibble_t   dbo,
    input  rtc_pkg::bcd_time_t time_q,
    input  rtc_pkg::bcd_date_t date_q,
    input  logic               mode_24h,
    input  rtc_pkg::nibble_t   ram_q,
    output logic               ack,
    output logic [7:0]         dbi,
    output rtc_pkg::reg_wr_t   wr,
    output logic               te
);

    rtc_pkg::nibble_t  ptr_q;
    rtc_pkg::nibble_t  mode_q;
    rtc_pkg::rtc_bank_t bank;
    logic              wr_cyc;
    rtc_pkg::nibble_t  rd_field;
    logic              rd_hit;

    assign wr_cyc = req & wrt;
    assign bank   = rtc_pkg::rtc_bank_t'(mode_q[1:0]);
    assign te     = mode_q[rtc_pkg::mode_te_bit];

    // Data writes go out on the bus, pointer writes stay here
    assign wr.en   = wr_cyc & adr0;
    assign wr.bank = bank;
    assign wr.ptr  = ptr_q;
    assign wr.data = dbo;

    always_ff @(posedge clk21m) begin
        if (reset) begin
            ack    <= 1'b0;
            ptr_q  <= '0;
            mode_q <= rtc_pkg::mode_reset_value;
        end else begin
            ack <= req;
            if (wr_cyc && !adr0) begin
                ptr_q <= dbo;
            end
            if (wr_cyc && adr0 && ptr_q == rtc_pkg::reg_mode_addr) begin
                mode_q <= dbo;
            end
        end
    end

    // Field select, zero-extended into the low nibble
    always_comb begin
        rd_field = 4'h0;
        rd_hit   = 1'b0;
        if (ptr_q == rtc_pkg::reg_mode_addr) begin
            rd_field = mode_q;
            rd_hit   = 1'b1;
        end else begin
            case (bank)
                rtc_pkg::bank_clock: begin
                    rd_hit = 1'b1;
                    case (ptr_q)
                        rtc_pkg::reg_sec_l_addr: rd_field = time_q.sec_l;
                        rtc_pkg::reg_sec_h_addr: rd_field = {1'b0, time_q.sec_h};
                        rtc_pkg::reg_min_l_addr: rd_field = time_q.min_l;
                        rtc_pkg::reg_min_h_addr: rd_field = {1'b0, time_q.min_h};
                        rtc_pkg::reg_hou_l_addr: rd_field = time_q.hou_l;
                        rtc_pkg::reg_hou_h_addr: rd_field = {2'b00, time_q.hou_h};
                        rtc_pkg::reg_wee_addr:   rd_field = {1'b0, date_q.wee};
                        rtc_pkg::reg_day_l_addr: rd_field = date_q.day_l;
                        rtc_pkg::reg_day_h_addr: rd_field = {2'b00, date_q.day_h};
                        rtc_pkg::reg_mon_l_addr: rd_field = date_q.mon_l;
                        rtc_pkg::reg_mon_h_addr: rd_field = {3'b000, date_q.mon_h};
                        rtc_pkg::reg_yea_l_addr: rd_field = date_q.yea_l;
                        rtc_pkg::reg_yea_h_addr: rd_field = date_q.yea_h;
                        default:                 rd_hit   = 1'b0;
                    endcase
                end
                rtc_pkg::bank_config: begin
                    if (ptr_q == rtc_pkg::reg_1224_addr) begin
                        rd_field = {3'b000, mode_24h};
                        rd_hit   = 1'b1;
                    end else if (ptr_q == rtc_pkg::reg_leap_addr) begin
                        rd_field = {2'b00, date_q.leap};
                        rd_hit   = 1'b1;
                    end
                end
                default: begin
                    // Both RAM banks
                    rd_field = ram_q;
                    rd_hit   = 1'b1;
                end
            endcase
        end
    end

    // Pointer port and unmapped registers float high
    assign dbi = (adr0 && rd_hit) ? {4'hF, rd_field} : 8'hFF;

endmodule

`default_nettype wire

/* timekeeping/rtc_time_counter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Prescaler and BCD time of day. Counts seconds from clkena pulses,
// carries through minutes and hours, flags the day wrap to the calendar.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rtc_time_counter #(
    parameter int ticks_per_sec = 10
) (
    input  logic               clk21m,
    input  logic               reset,
    input  logic               clkena,
    input  logic               te,
    input  rtc_pkg::reg_wr_t   wr,
    output rtc_pkg::bcd_time_t time_q,
    output logic               mode_24h,
    output logic               day_tick
);

    localparam int cnt_w = (ticks_per_sec > 1) ? $clog2(ticks_per_sec) : 1;
    localparam logic [cnt_w-1:0] presc_reload = cnt_w'(ticks_per_sec - 1);

    logic [cnt_w-1:0] presc_q;
    logic             tick_en;
    logic             presc_rst;
    logic             wr_clock;
    logic             sec_tick;
    logic             c_sec_h;
    logic             c_min_l;
    logic             c_min_h;
    logic             hour_step;
    logic             hour_wrap;

    assign wr_clock  = wr.en && wr.bank == rtc_pkg::bank_clock;
    assign presc_rst = wr.en && wr.bank == rtc_pkg::bank_config &&
                       wr.ptr == rtc_pkg::reg_reset_addr && wr.data[1];

    assign tick_en  = clkena & te;
    assign sec_tick = tick_en && presc_q == '0;

    // Carry chain, all in the same cycle as sec_tick
    assign c_sec_h   = sec_tick && time_q.sec_l == 4'd9;
    assign c_min_l   = c_sec_h && time_q.sec_h == 3'd5;
    assign c_min_h   = c_min_l && time_q.min_l == 4'd9;
    assign hour_step = c_min_h && time_q.min_h == 3'd5;

    // 23 in 24-hour mode, 11 in 12-hour mode
    assign hour_wrap = mode_24h ? (time_q.hou_h == 2'd2 && time_q.hou_l == 4'd3)
                                : (time_q.hou_h[0] && time_q.hou_l == 4'd1);

    // In 12-hour mode only the afternoon wrap starts a new day
    assign day_tick = hour_step && hour_wrap && (mode_24h || time_q.hou_h[1]);

    always_ff @(posedge clk21m) begin
        if (reset) begin
            presc_q <= presc_reload;
        end else if (presc_rst || sec_tick) begin
            presc_q <= presc_reload;
        end else if (tick_en) begin
            presc_q <= presc_q - 1'b1;
        end
    end

    always_ff @(posedge clk21m) begin
        if (reset) begin
            time_q   <= '0;
            mode_24h <= 1'b1;
        end else begin
            if (sec_tick) begin
                time_q.sec_l <= (time_q.sec_l == 4'd9) ? 4'd0 : time_q.sec_l + 4'd1;
            end
            if (c_sec_h) begin
                time_q.sec_h <= (time_q.sec_h == 3'd5) ? 3'd0 : time_q.sec_h + 3'd1;
            end
            if (c_min_l) begin
                time_q.min_l <= (time_q.min_l == 4'd9) ? 4'd0 : time_q.min_l + 4'd1;
            end
            if (c_min_h) begin
                time_q.min_h <= (time_q.min_h == 3'd5) ? 3'd0 : time_q.min_h + 3'd1;
            end
            if (hour_step) begin
                if (hour_wrap) begin
                    time_q.hou_l <= 4'd0;
                    // 12-hour wrap flips the afternoon flag
                    time_q.hou_h <= mode_24h ? 2'd0 : {~time_q.hou_h[1], 1'b0};
                end else if (time_q.hou_l == 4'd9) begin
                    time_q.hou_l <= 4'd0;
                    time_q.hou_h <= time_q.hou_h + 2'd1;
                end else begin
                    time_q.hou_l <= time_q.hou_l + 4'd1;
                end
            end
            // Host writes come last and override the count
            if (wr_clock) begin
                case (wr.ptr)
                    rtc_pkg::reg_sec_l_addr: time_q.sec_l <= wr.data;
                    rtc_pkg::reg_sec_h_addr: time_q.sec_h <= wr.data[2:0];
                    rtc_pkg::reg_min_l_addr: time_q.min_l <= wr.data;
                    rtc_pkg::reg_min_h_addr: time_q.min_h <= wr.data[2:0];
                    rtc_pkg::reg_hou_l_addr: time_q.hou_l <= wr.data;
                    rtc_pkg::reg_hou_h_addr: time_q.hou_h <= wr.data[1:0];
                    default: ;
                endcase
            end
            if (wr.en && wr.bank == rtc_pkg::bank_config &&
                wr.ptr == rtc_pkg::reg_1224_addr) begin
                mode_24h <= wr.data[0];
            end
        end
    end

endmodule

`default_nettype wire

/* timekeeping/rtc_calendar.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// BCD calendar: weekday, day, month, year and leap counter.
// Advances on day_tick from the time counter.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rtc_calendar (
    input  logic               clk21m,
    input  logic               reset,
    input  rtc_pkg::reg_wr_t   wr,
    input  logic               day_tick,
    output rtc_pkg::bcd_date_t date_q
);

    logic [4:0] month;
    logic [5:0] day;
    logic [5:0] last_day;
    logic       month_end;
    logic       year_end;
    logic       c_mon;
    logic       c_year;
    logic       c_yea_h;
    logic       wr_clock;
    logic       wr_leap;

    assign month = {date_q.mon_h, date_q.mon_l};
    assign day   = {date_q.day_h, date_q.day_l};

    // Month length in BCD
    always_comb begin
        case (month)
            5'h04, 5'h06, 5'h09, 5'h11: last_day = 6'h30;
            5'h02:                      last_day = (date_q.leap == 2'd0) ? 6'h29 : 6'h28;
            default:                    last_day = 6'h31;
        endcase
    end

    assign month_end = day == last_day;
    assign year_end  = month == 5'h12;

    assign c_mon   = day_tick && month_end;
    assign c_year  = c_mon && year_end;
    assign c_yea_h = c_year && date_q.yea_l == 4'd9;

    assign wr_clock = wr.en && wr.bank == rtc_pkg::bank_clock;
    assign wr_leap  = wr.en && wr.bank == rtc_pkg::bank_config &&
                      wr.ptr == rtc_pkg::reg_leap_addr;

    always_ff @(posedge clk21m) begin
        if (reset) begin
            date_q       <= '0;
            date_q.day_l <= 4'd1;
            date_q.mon_l <= 4'd1;
        end else begin
            if (day_tick) begin
                date_q.wee <= (date_q.wee == 3'd6) ? 3'd0 : date_q.wee + 3'd1;
                if (month_end) begin
                    date_q.day_h <= 2'd0;
                    date_q.day_l <= 4'd1;
                end else if (date_q.day_l == 4'd9) begin
                    date_q.day_l <= 4'd0;
                    date_q.day_h <= date_q.day_h + 2'd1;
                end else begin
                    date_q.day_l <= date_q.day_l + 4'd1;
                end
            end
            if (c_mon) begin
                if (year_end) begin
                    date_q.mon_h <= 1'b0;
                    date_q.mon_l <= 4'd1;
                end else if (date_q.mon_l == 4'd9) begin
                    date_q.mon_h <= 1'b1;
                    date_q.mon_l <= 4'd0;
                end else begin
                    date_q.mon_l <= date_q.mon_l + 4'd1;
                end
            end
            if (c_year) begin
                date_q.yea_l <= (date_q.yea_l == 4'd9) ? 4'd0 : date_q.yea_l + 4'd1;
                date_q.leap  <= date_q.leap + 2'd1;
            end
            if (c_yea_h) begin
                date_q.yea_h <= (date_q.yea_h == 4'd9) ? 4'd0 : date_q.yea_h + 4'd1;
            end
            // Host writes override the count
            if (wr_clock) begin
                case (wr.ptr)
                    rtc_pkg::reg_wee_addr:   date_q.wee   <= wr.data[2:0];
                    rtc_pkg::reg_day_l_addr: date_q.day_l <= wr.data;
                    rtc_pkg::reg_day_h_addr: date_q.day_h <= wr.data[1:0];
                    rtc_pkg::reg_mon_l_addr: date_q.mon_l <= wr.data;
                    rtc_pkg::reg_mon_h_addr: date_q.mon_h <= wr.data[0];
                    rtc_pkg::reg_yea_l_addr: date_q.yea_l <= wr.data;
                    rtc_pkg::reg_yea_h_addr: date_q.yea_h <= wr.data;
                    default: ;
                endcase
            end
            if (wr_leap) begin
                date_q.leap <= wr.data[1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/rtc_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MSX2 real-time clock top level. Host port on req/wrt/adr/dbo,
// one-cycle ack, 10 Hz clkena strobe drives the time base.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rtc_top #(
    parameter int ticks_per_sec = 10
) (
    input  logic        clk21m,
    input  logic        reset,
    input  logic        clkena,
    input  logic        req,
    input  logic        wrt,
    input  logic [15:0] adr,
    input  logic [7:0]  dbo,
    output logic        ack,
    output logic [7:0]  dbi
);

    rtc_pkg::reg_wr_t   wr;
    rtc_pkg::bcd_time_t time_q;
    rtc_pkg::bcd_date_t date_q;
    rtc_pkg::nibble_t   ram_q;
    logic               te;
    logic               mode_24h;
    logic               day_tick;

    // Only adr[0] and the low data nibble reach the chip
    rtc_bus_regs bus_regs_i (
        .clk21m   (clk21m),
        .reset    (reset),
        .req      (req),
        .wrt      (wrt),
        .adr0     (adr[0]),
        .dbo      (dbo[3:0]),
        .time_q   (time_q),
        .date_q   (date_q),
        .mode_24h (mode_24h),
        .ram_q    (ram_q),
        .ack      (ack),
        .dbi      (dbi),
        .wr       (wr),
        .te       (te)
    );

    rtc_time_counter #(
        .ticks_per_sec (ticks_per_sec)
    ) time_counter_i (
        .clk21m   (clk21m),
        .reset    (reset),
        .clkena   (clkena),
        .te       (te),
        .wr       (wr),
        .time_q   (time_q),
        .mode_24h (mode_24h),
        .day_tick (day_tick)
    );

    rtc_calendar calendar_i (
        .clk21m   (clk21m),
        .reset    (reset),
        .wr       (wr),
        .day_tick (day_tick),
        .date_q   (date_q)
    );

    rtc_backup_ram backup_ram_i (
        .clk21m (clk21m),
        .wr     (wr),
        .ram_q  (ram_q)
    );

endmodule

`default_nettype wire

/* bench/rtc_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the MSX2 RTC top level. Runs the register port,
// backup RAM, prescaler, rollover and calendar tests, then prints a verdict.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rtc_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ack_limit = 8;

    logic        clk21m;
    logic        reset;
    logic        clkena;
    logic        req;
    logic        wrt;
    logic [15:0] adr;
    logic [7:0]  dbo;
    logic        ack;
    logic [7:0]  dbi;
    int          errors;
    int          timeouts;

    rtc_top #(
        .ticks_per_sec (10)
    ) dut_i (
        .clk21m (clk21m),
        .reset  (reset),
        .clkena (clkena),
        .req    (req),
        .wrt    (wrt),
        .adr    (adr),
        .dbo    (dbo),
        .ack    (ack),
        .dbi    (dbi)
    );

    initial begin
        clk21m = 1'b0;
        forever #2 clk21m = ~clk21m;
    end

    task automatic report_mismatch(input string msg, input logic [7:0] got,
                                   input logic [7:0] exp);
        errors++;
        $display("FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
    endtask

    // One host access; ack must arrive exactly one cycle after req
    task automatic bus_cycle(input logic is_wr, input logic a0, input logic [7:0] wdata,
                             output logic [7:0] rdata);
        int n;
        @(negedge clk21m);
        if (ack !== 1'b0) begin
            errors++;
            $display("ack was high at %0t ns with no request in the cycle before", $time);
        end
        req = 1'b1;
        wrt = is_wr;
        adr = {15'd0, a0};
        dbo = wdata;
        @(negedge clk21m);
        rdata = dbi;
        req = 1'b0;
        wrt = 1'b0;
        n = 0;
        while (ack !== 1'b1 && n < ack_limit) begin
            @(negedge clk21m);
            n++;
        end
        if (ack !== 1'b1) begin
            timeouts++;
            $display("Timeout at %0t ns: no ack within %0d cycles", $time, ack_limit);
        end else if (n != 0) begin
            errors++;
            $display("ack came %0d cycles late at %0t ns", n, $time);
        end
    endtask

    task automatic write_ptr(input logic [3:0] ptr);
        logic [7:0] unused;
        bus_cycle(1'b1, 1'b0, {4'h0, ptr}, unused);
    endtask

    task automatic write_data(input logic [3:0] data);
        logic [7:0] unused;
        bus_cycle(1'b1, 1'b1, {4'h0, data}, unused);
    endtask

    task automatic read_data(input logic a0, output logic [7:0] value);
        bus_cycle(1'b0, a0, 8'h00, value);
    endtask

    // Single clkena strobe once the bus has gone idle
    task automatic pulse_clkena();
        int n;
        @(negedge clk21m);
        n = 0;
        while (ack !== 1'b0 && n < ack_limit) begin
            @(negedge clk21m);
            n++;
        end
        if (ack !== 1'b0) begin
            timeouts++;
            $display("Timeout at %0t ns: ack did not drop before clkena", $time);
        end
        clkena = 1'b1;
        @(negedge clk21m);
        clkena = 1'b0;
    endtask

    task automatic pulse_n(input int count);
        repeat (count) pulse_clkena();
    endtask

    task automatic write_reg(input logic [3:0] ptr, input logic [3:0] data);
        write_ptr(ptr);
        write_data(data);
    endtask

    task automatic read_reg(input logic [3:0] ptr, output logic [7:0] value);
        write_ptr(ptr);
        read_data(1'b1, value);
    endtask

    task automatic select_mode(input logic [3:0] mode);
        write_reg(rtc_pkg::reg_mode_addr, mode);
    endtask

    // Write into the config bank, then go back to the clock bank, timer on
    task automatic config_write(input logic [3:0] ptr, input logic [3:0] data);
        select_mode(4'b1001);
        write_reg(ptr, data);
        select_mode(4'b1000);
    endtask

    task automatic expect_reg(input logic [3:0] ptr, input logic [3:0] exp, input string msg);
        logic [7:0] value;
        read_reg(ptr, value);
        if (value !== {4'hF, exp}) begin
            report_mismatch(msg, value, {4'hF, exp});
        end
    endtask

    // Arguments are BCD bytes; hh[5] is the afternoon flag
    task automatic load_time(input logic [7:0] hh, input logic [7:0] mm, input logic [7:0] ss);
        write_reg(4'd0, ss[3:0]);
        write_reg(4'd1, ss[7:4]);
        write_reg(4'd2, mm[3:0]);
        write_reg(4'd3, mm[7:4]);
        write_reg(4'd4, hh[3:0]);
        write_reg(4'd5, hh[7:4]);
    endtask

    task automatic check_time(input logic [7:0] hh, input logic [7:0] mm, input logic [7:0] ss,
                              input string msg);
        expect_reg(4'd0, ss[3:0], {msg, " sec_l"});
        expect_reg(4'd1, ss[7:4], {msg, " sec_h"});
        expect_reg(4'd2, mm[3:0], {msg, " min_l"});
        expect_reg(4'd3, mm[7:4], {msg, " min_h"});
        expect_reg(4'd4, hh[3:0], {msg, " hou_l"});
        expect_reg(4'd5, hh[7:4], {msg, " hou_h"});
    endtask

    task automatic load_date(input logic [3:0] wee, input logic [7:0] dd, input logic [7:0] mo,
                             input logic [7:0] yy);
        write_reg(4'd6, wee);
        write_reg(4'd7, dd[3:0]);
        write_reg(4'd8, dd[7:4]);
        write_reg(4'd9, mo[3:0]);
        write_reg(4'd10, mo[7:4]);
        write_reg(4'd11, yy[3:0]);
        write_reg(4'd12, yy[7:4]);
    endtask

    task automatic check_date(input logic [3:0] wee, input logic [7:0] dd, input logic [7:0] mo,
                              input logic [7:0] yy, input string msg);
        expect_reg(4'd6, wee, {msg, " weekday"});
        expect_reg(4'd7, dd[3:0], {msg, " day_l"});
        expect_reg(4'd8, dd[7:4], {msg, " day_h"});
        expect_reg(4'd9, mo[3:0], {msg, " mon_l"});
        expect_reg(4'd10, mo[7:4], {msg, " mon_h"});
        expect_reg(4'd11, yy[3:0], {msg, " yea_l"});
        expect_reg(4'd12, yy[7:4], {msg, " yea_h"});
    endtask

    // Restart the prescaler, then one full second of enabled strobes
    task automatic advance_second();
        config_write(rtc_pkg::reg_reset_addr, 4'b0010);
        pulse_n(10);
    endtask

    // Implemented bits of each clock bank register
    function automatic logic [3:0] field_mask(input logic [3:0] ptr);
        case (ptr)
            4'd1, 4'd3, 4'd6: field_mask = 4'h7;
            4'd5, 4'd8:       field_mask = 4'h3;
            4'd10:            field_mask = 4'h1;
            default:          field_mask = 4'hF;
        endcase
    endfunction

    task automatic test_register_port();
        logic [3:0] data;
        logic [7:0] value;
        check_time(8'h00, 8'h00, 8'h00, "reset time");
        check_date(4'd0, 8'h01, 8'h01, 8'h00, "reset date");
        for (int p = 0; p < 13; p++) begin
            data = 4'($urandom);
            write_reg(4'(p), data);
            read_reg(4'(p), value);
            if (value !== {4'hF, data & field_mask(4'(p))}) begin
                report_mismatch("clock register readback", value, {4'hF, data & field_mask(4'(p))});
            end
        end
        data = 4'($urandom);
        select_mode(data);
        read_reg(rtc_pkg::reg_mode_addr, value);
        if (value !== {4'hF, data}) begin
            report_mismatch("mode register readback", value, {4'hF, data});
        end
        select_mode(4'b1000);
        read_data(1'b0, value);
        if (value !== 8'hFF) begin
            report_mismatch("pointer port read", value, 8'hFF);
        end
        @(negedge clk21m);
        if (ack !== 1'b0) begin
            report_mismatch("ack after idle cycle", {7'd0, ack}, 8'h00);
        end
    endtask

    task automatic test_backup_ram();
        logic [3:0] lo_val [16];
        logic [3:0] hi_val [16];
        logic [7:0] value;
        // Pointer 13 is the mode register in every bank
        select_mode(4'b1010);
        for (int p = 0; p < 16; p++) begin
            lo_val[p] = 4'($urandom);
            if (p != 13) write_reg(4'(p), lo_val[p]);
        end
        select_mode(4'b1011);
        for (int p = 0; p < 16; p++) begin
            hi_val[p] = 4'($urandom);
            if (p != 13) write_reg(4'(p), hi_val[p]);
        end
        select_mode(4'b1010);
        for (int p = 0; p < 16; p++) begin
            read_reg(4'(p), value);
            if (p != 13 && value !== {4'hF, lo_val[p]}) begin
                report_mismatch("bank 2 readback", value, {4'hF, lo_val[p]});
            end
        end
        select_mode(4'b1011);
        for (int p = 0; p < 16; p++) begin
            read_reg(4'(p), value);
            if (p != 13 && value !== {4'hF, hi_val[p]}) begin
                report_mismatch("bank 3 readback", value, {4'hF, hi_val[p]});
            end
        end
        select_mode(4'b1000);
    endtask

    task automatic test_prescaler();
        load_time(8'h00, 8'h00, 8'h04);
        select_mode(4'b0000);
        pulse_n(20);
        check_time(8'h00, 8'h00, 8'h04, "timer disabled");
        advance_second();
        check_time(8'h00, 8'h00, 8'h05, "after 10 strobes");
        // Leave the prescaler part way through a second
        pulse_n(4);
        config_write(rtc_pkg::reg_reset_addr, 4'b0010);
        pulse_n(9);
        expect_reg(4'd0, 4'd5, "after 9 strobes sec_l");
        pulse_clkena();
        expect_reg(4'd0, 4'd6, "after 10th strobe sec_l");
    endtask

    task automatic test_rollover();
        config_write(rtc_pkg::reg_1224_addr, 4'd1);
        load_time(8'h23, 8'h59, 8'h59);
        load_date(4'd6, 8'h15, 8'h03, 8'h24);
        advance_second();
        check_time(8'h00, 8'h00, 8'h00, "24h wrap");
        check_date(4'd0, 8'h16, 8'h03, 8'h24, "24h wrap");
        config_write(rtc_pkg::reg_1224_addr, 4'd0);
        load_time(8'h11, 8'h59, 8'h59);
        advance_second();
        check_time(8'h20, 8'h00, 8'h00, "12h morning wrap");
        check_date(4'd0, 8'h16, 8'h03, 8'h24, "12h morning wrap");
        load_time(8'h31, 8'h59, 8'h59);
        advance_second();
        check_time(8'h00, 8'h00, 8'h00, "12h afternoon wrap");
        check_date(4'd1, 8'h17, 8'h03, 8'h24, "12h afternoon wrap");
        config_write(rtc_pkg::reg_1224_addr, 4'd1);
    endtask

    task automatic run_day_case(input logic [1:0] leap, input logic [3:0] wee,
                                input logic [7:0] dd, input logic [7:0] mo,
                                input logic [7:0] yy);
        config_write(rtc_pkg::reg_leap_addr, {2'b00, leap});
        load_time(8'h23, 8'h59, 8'h59);
        load_date(wee, dd, mo, yy);
        advance_second();
    endtask

    task automatic test_month_year();
        run_day_case(2'd0, 4'd2, 8'h30, 8'h04, 8'h24);
        check_date(4'd3, 8'h01, 8'h05, 8'h24, "end of April");
        run_day_case(2'd1, 4'd5, 8'h28, 8'h02, 8'h25);
        check_date(4'd6, 8'h01, 8'h03, 8'h25, "February, common year");
        run_day_case(2'd0, 4'd6, 8'h28, 8'h02, 8'h24);
        check_date(4'd0, 8'h29, 8'h02, 8'h24, "February 28, leap year");
        load_time(8'h23, 8'h59, 8'h59);
        advance_second();
        check_date(4'd1, 8'h01, 8'h03, 8'h24, "February 29, leap year");
        run_day_case(2'd2, 4'd3, 8'h31, 8'h12, 8'h99);
        check_date(4'd4, 8'h01, 8'h01, 8'h00, "end of century");
        select_mode(4'b1001);
        expect_reg(rtc_pkg::reg_leap_addr, 4'd3, "leap counter after year wrap");
        select_mode(4'b1000);
    endtask

    initial begin : main_seq
        logic [31:0] seed_val;
        seed_val = $urandom(32'h62ce_ea8b);
        errors   = 0;
        timeouts = 0;
        reset    = 1'b1;
        clkena   = 1'b0;
        req      = 1'b0;
        wrt      = 1'b0;
        adr      = 16'h0000;
        dbo      = 8'h00;
        repeat (5) @(posedge clk21m);
        @(negedge clk21m);
        reset = 1'b0;
        test_register_port();
        test_backup_ram();
        test_prescaler();
        test_rollover();
        test_month_year();
        $display("Run complete: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
common/rtc_pkg.sv
verilog/rtc_backup_ram.sv
verilog/rtc_bus_regs.sv
timekeeping/rtc_time_counter.sv
timekeeping/rtc_calendar.sv
verilog/rtc_top.sv
bench/rtc_tb.sv
